//--- mesh_noc_top.f
noc_pkg.sv
flit_fifo.sv
port_arbiter.sv
mesh_router.sv
event_counter.sv
stat_apb_slave.sv
mesh_noc_top.sv
mesh_noc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mesh NoC testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f mesh_noc_top.f \
    --top-module mesh_noc_tb -o Vmesh_noc_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vmesh_noc_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0

//--- mesh_noc_tb.sv
`timescale 1ns/100ps

module mesh_noc_tb;
    import noc_pkg::*;

    localparam int FLITS_PER_SRC  = 50;  // 200 flits over four sources
    localparam int TOTAL_FLITS    = FLITS_PER_SRC * NR;
    localparam int TIMEOUT_CYCLES = 200 * 3 * 4 + 500;  // flits x hops x 4, plus slack

    logic                 clk       = 1'b0;
    logic                 rst_n     = 1'b0;
    logic [NR-1:0]        in_valid  = '0;
    logic [NR*FLIT_W-1:0] in_flit   = '0;
    logic [NR-1:0]        out_ready = '1;
    logic                 psel      = 1'b0;
    logic                 penable   = 1'b0;
    logic                 pwrite    = 1'b0;
    logic [31:0]          paddr     = '0;
    logic [31:0]          pwdata    = '0;
    wire  [NR-1:0]        in_ready;
    wire  [NR-1:0]        out_valid;
    wire  [NR*FLIT_W-1:0] out_flit;
    wire  [31:0]          prdata;
    wire                  pready;
    wire                  pslverr;

    logic [FLIT_W-1:0] sent_q [NR*NR][$];  // index src*NR + dst, send order
    int sent_cnt [NR][NR];
    int delivered [NR][NR];
    int issued [NR];  // flits presented per source
    int stall_left [NR];  // sink stall stretch per endpoint
    bit traffic_on;
    bit saw_stall;  // in_valid seen against low in_ready
    int err_check;  // scoreboard process
    int err_main;  // reset and APB checks
    int cycles;

    mesh_noc_top dut (.*);

    always #50 clk = ~clk;  // 100 ns period

    // routers on the XY path, both ends included
    function automatic int expected_hops(int src, int dst);
        int dx;
        int dy;
        dx = (src % NX) - (dst % NX);
        dy = (src / NX) - (dst / NX);
        if (dx < 0) dx = -dx;
        if (dy < 0) dy = -dy;
        return dx + dy + 1;
    endfunction

    // walk x first, then y, and see whether router r is visited
    function automatic bit on_path(int r, int src, int dst);
        int x;
        int y;
        bit hit;
        x   = src % NX;
        y   = src / NX;
        hit = (r == src);
        while (x != dst % NX) begin
            x = (dst % NX > x) ? x + 1 : x - 1;
            if (y * NX + x == r) hit = 1'b1;
        end
        while (y != dst / NX) begin
            y = (dst / NX > y) ? y + 1 : y - 1;
            if (y * NX + x == r) hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic int expected_router(int r);
        int sum;
        sum = 0;
        for (int s = 0; s < NR; s++)
            for (int d = 0; d < NR; d++)
                if (on_path(r, s, d)) sum += sent_cnt[s][d];
        return sum;
    endfunction

    function automatic int expected_events();
        int sum;
        sum = 0;
        for (int s = 0; s < NR; s++)
            for (int d = 0; d < NR; d++)
                sum += delivered[s][d] * expected_hops(s, d);
        return sum;
    endfunction

    function automatic bit traffic_drained();
        bit idle;
        idle = (in_valid == '0);
        for (int s = 0; s < NR; s++) if (issued[s] != FLITS_PER_SRC) idle = 1'b0;
        for (int q = 0; q < NR * NR; q++) if (sent_q[q].size() != 0) idle = 1'b0;
        return idle;
    endfunction

    // one APB transfer, result taken on the pready edge
    task automatic apb_access(input logic wr, input logic [31:0] addr,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel   <= 1'b1;
        pwrite <= wr;
        paddr  <= addr;
        pwdata <= 32'hffff_ffff;  // any data clears
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready) @(posedge clk);  // watchdog bounds this
        rdata = prdata;
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    // sources and sinks
    always @(posedge clk) begin
        logic [FLIT_W-1:0] fl;
        int d;
        if (rst_n) begin
            for (int s = 0; s < NR; s++) begin
                if (in_valid[s] && in_ready[s]) begin  // accepted on this edge
                    fl = in_flit[s*FLIT_W +: FLIT_W];
                    d  = int'(fl[DST_Y_BIT]) * NX + int'(fl[DST_X_BIT]);
                    sent_q[s*NR + d].push_back(fl);
                    sent_cnt[s][d]++;
                end
                if (in_valid[s] && !in_ready[s]) saw_stall = 1'b1;
                if (!in_valid[s] || in_ready[s]) begin  // free to present a new flit
                    if (traffic_on && issued[s] < FLITS_PER_SRC) begin
                        d  = int'($urandom % NR);  // own tile included
                        fl = {1'(d % NX), 1'(d / NX), 2'(s), 12'($urandom)};
                        in_flit[s*FLIT_W +: FLIT_W] <= fl;
                        in_valid[s] <= 1'b1;
                        issued[s]++;
                    end else begin
                        in_valid[s] <= 1'b0;
                    end
                end
                if (stall_left[s] > 0) begin  // sink stalled
                    stall_left[s]--;
                    out_ready[s] <= 1'b0;
                end else if (traffic_on && issued[s] < FLITS_PER_SRC
                             && ($urandom % 16) == 0) begin
                    stall_left[s] = int'($urandom % 12) + 4;  // 4..15 cycles low
                    out_ready[s] <= 1'b0;
                end else begin
                    out_ready[s] <= 1'b1;
                end
            end
        end
    end

    // scoreboard
    always @(posedge clk) begin
        logic [FLIT_W-1:0] got;
        logic [FLIT_W-1:0] want;
        int s;
        int dst;
        if (rst_n) begin
            for (int d = 0; d < NR; d++) begin
                if (out_valid[d] && out_ready[d]) begin
                    got = out_flit[d*FLIT_W +: FLIT_W];
                    s   = int'(got[13:12]);  // source id field
                    dst = int'(got[DST_Y_BIT]) * NX + int'(got[DST_X_BIT]);
                    if (dst != d) begin
                        err_check++;
                        $display("ERR %0t out_flit[%0d] dest exp %0d got %0d", $time, d, d, dst);
                    end else if (sent_q[s*NR + d].size() == 0) begin
                        err_check++;
                        $display("%0t: endpoint %0d got flit %h with nothing outstanding",
                                 $time, d, got);
                    end else begin
                        want = sent_q[s*NR + d].pop_front();  // oldest of this pair
                        delivered[s][d]++;
                        if (got != want) begin
                            err_check++;
                            $display("ERR %0t out_flit[%0d] exp %h got %h", $time, d, want, got);
                        end
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, traffic or APB access did not finish", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] rdata;
        logic        err;
        int          seed_ret;
        int          total;
        int          want;
        seed_ret = $urandom(56208);
        repeat (5) @(posedge clk);  // reset for 5 cycles
        rst_n <= 1'b1;
        @(negedge clk);
        if (out_valid != '0) begin
            err_main++;
            $display("ERR %0t out_valid exp 0 got %b", $time, out_valid);
        end
        if (pready || pslverr) begin
            err_main++;
            $display("ERR %0t pready/pslverr exp 0/0 got %b/%b", $time, pready, pslverr);
        end
        @(posedge clk);
        traffic_on <= 1'b1;
        @(negedge clk);
        while (!traffic_drained()) @(negedge clk);
        repeat (2) @(negedge clk);
        if (!saw_stall) begin
            err_main++;
            $display("in_ready never dropped under sustained load");
        end
        total = 0;
        for (int s = 0; s < NR; s++)
            for (int d = 0; d < NR; d++) total += delivered[s][d];
        if (total != TOTAL_FLITS) begin
            err_main++;
            $display("ERR %0t delivered exp %0d got %0d", $time, TOTAL_FLITS, total);
        end
        total = 0;
        for (int r = 0; r < NR; r++) begin  // per-router counters
            apb_access(1'b0, 32'(r * 4), rdata, err);
            total += int'(rdata);
            if (rdata != 32'(expected_router(r)) || err) begin
                err_main++;
                $display("ERR %0t prdata[router %0d] exp %0d got %0d (pslverr %b)",
                         $time, r, expected_router(r), rdata, err);
            end
        end
        if (total != expected_events()) begin
            err_main++;
            $display("ERR %0t counter sum exp %0d got %0d", $time, expected_events(), total);
        end
        apb_access(1'b1, 32'h8, rdata, err);  // clear router 2
        for (int r = 0; r < NR; r++) begin
            apb_access(1'b0, 32'(r * 4), rdata, err);
            want = (r == 2) ? 0 : expected_router(r);
            if (rdata != 32'(want)) begin
                err_main++;
                $display("ERR %0t prdata[router %0d] exp %0d got %0d", $time, r, want, rdata);
            end
        end
        apb_access(1'b0, 32'd16, rdata, err);  // out of range
        if (!err || rdata != '0) begin
            err_main++;
            $display("ERR %0t pslverr/prdata exp 1/0 got %b/%h", $time, err, rdata);
        end
        $display("errors: %0d scoreboard, %0d control", err_check, err_main);
        if (err_check + err_main == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- mesh_noc_top.sv
`timescale 1ns/100ps

module mesh_noc_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [noc_pkg::NR-1:0]                 in_valid,
    input  logic [noc_pkg::NR*noc_pkg::FLIT_W-1:0] in_flit,
    output wire  [noc_pkg::NR-1:0]                 in_ready,
    output wire  [noc_pkg::NR-1:0]                 out_valid,
    output wire  [noc_pkg::NR*noc_pkg::FLIT_W-1:0] out_flit,
    input  logic [noc_pkg::NR-1:0]                 out_ready,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [31:0]                            paddr,
    input  logic [31:0]                            pwdata,
    output logic [31:0]                            prdata,
    output logic                                   pready,
    output logic                                   pslverr
);
    import noc_pkg::*;

    wire [NP-1:0]        r_in_valid [NR];  // per router, per port
    wire [NP-1:0]        r_in_ready [NR];
    wire [NP*FLIT_W-1:0] r_in_flit [NR];
    wire [NP-1:0]        r_out_valid [NR];
    wire [NP-1:0]        r_out_ready [NR];
    wire [NP*FLIT_W-1:0] r_out_flit [NR];
    wire [EV_W-1:0]      r_event [NR];
    wire [NR*CNT_W-1:0]  counts;  // all counters packed
    wire [NR-1:0]        clear;

    for (genvar y = 0; y < NY; y++) begin : g_y
        for (genvar x = 0; x < NX; x++) begin : g_x
            localparam int RID = y * NX + x;

            mesh_router #(
                .ROUTER_X (x),
                .ROUTER_Y (y)
            ) u_router (
                .clk          (clk),
                .rst_n        (rst_n),
                .in_valid     (r_in_valid[RID]),
                .in_flit      (r_in_flit[RID]),
                .in_ready     (r_in_ready[RID]),
                .out_valid    (r_out_valid[RID]),
                .out_flit     (r_out_flit[RID]),
                .out_ready    (r_out_ready[RID]),
                .router_event (r_event[RID])
            );

            event_counter u_cnt (
                .clk          (clk),
                .rst_n        (rst_n),
                .router_event (r_event[RID]),
                .clear        (clear[RID]),
                .count        (counts[RID*CNT_W +: CNT_W])
            );

            // endpoint on the local port
            assign r_in_valid[RID][P_LOCAL]                  = in_valid[RID];
            assign r_in_flit[RID][P_LOCAL*FLIT_W +: FLIT_W]  = in_flit[RID*FLIT_W +: FLIT_W];
            assign in_ready[RID]                             = r_in_ready[RID][P_LOCAL];
            assign out_valid[RID]                            = r_out_valid[RID][P_LOCAL];
            assign out_flit[RID*FLIT_W +: FLIT_W] = r_out_flit[RID][P_LOCAL*FLIT_W +: FLIT_W];
            assign r_out_ready[RID][P_LOCAL]                 = out_ready[RID];

            if (x < NX - 1) begin : g_east  // east in from neighbour's west out
                assign r_in_valid[RID][P_EAST] = r_out_valid[RID+1][P_WEST];
                assign r_in_flit[RID][P_EAST*FLIT_W +: FLIT_W] =
                    r_out_flit[RID+1][P_WEST*FLIT_W +: FLIT_W];
                assign r_out_ready[RID][P_EAST] = r_in_ready[RID+1][P_WEST];
            end else begin : g_east_edge  // grounded edge
                assign r_in_valid[RID][P_EAST]                  = 1'b0;
                assign r_in_flit[RID][P_EAST*FLIT_W +: FLIT_W]  = '0;
                assign r_out_ready[RID][P_EAST]                 = 1'b1;
            end

            if (y > 0) begin : g_north  // row above
                assign r_in_valid[RID][P_NORTH] = r_out_valid[RID-NX][P_SOUTH];
                assign r_in_flit[RID][P_NORTH*FLIT_W +: FLIT_W] =
                    r_out_flit[RID-NX][P_SOUTH*FLIT_W +: FLIT_W];
                assign r_out_ready[RID][P_NORTH] = r_in_ready[RID-NX][P_SOUTH];
            end else begin : g_north_edge
                assign r_in_valid[RID][P_NORTH]                 = 1'b0;
                assign r_in_flit[RID][P_NORTH*FLIT_W +: FLIT_W] = '0;
                assign r_out_ready[RID][P_NORTH]                = 1'b1;
            end

            if (x > 0) begin : g_west
                assign r_in_valid[RID][P_WEST] = r_out_valid[RID-1][P_EAST];
                assign r_in_flit[RID][P_WEST*FLIT_W +: FLIT_W] =
                    r_out_flit[RID-1][P_EAST*FLIT_W +: FLIT_W];
                assign r_out_ready[RID][P_WEST] = r_in_ready[RID-1][P_EAST];
            end else begin : g_west_edge
                assign r_in_valid[RID][P_WEST]                  = 1'b0;
                assign r_in_flit[RID][P_WEST*FLIT_W +: FLIT_W]  = '0;
                assign r_out_ready[RID][P_WEST]                 = 1'b1;
            end

            if (y < NY - 1) begin : g_south  // row below
                assign r_in_valid[RID][P_SOUTH] = r_out_valid[RID+NX][P_NORTH];
                assign r_in_flit[RID][P_SOUTH*FLIT_W +: FLIT_W] =
                    r_out_flit[RID+NX][P_NORTH*FLIT_W +: FLIT_W];
                assign r_out_ready[RID][P_SOUTH] = r_in_ready[RID+NX][P_NORTH];
            end else begin : g_south_edge
                assign r_in_valid[RID][P_SOUTH]                 = 1'b0;
                assign r_in_flit[RID][P_SOUTH*FLIT_W +: FLIT_W] = '0;
                assign r_out_ready[RID][P_SOUTH]                = 1'b1;
            end
        end
    end

    stat_apb_slave u_apb (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .counts  (counts),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .clear   (clear)
    );

endmodule

//--- stat_apb_slave.sv
`timescale 1ns/100ps

module stat_apb_slave (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [31:0]                       paddr,
    input  logic [31:0]                       pwdata,
    input  logic [noc_pkg::NR*noc_pkg::CNT_W-1:0] counts,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic [noc_pkg::NR-1:0]            clear
);
    import noc_pkg::*;

    apb_state_e       state;
    logic [RID_W-1:0] sel;  // router index from paddr[3:2]
    logic             out_of_range;

    assign sel          = paddr[RID_W+1:2];
    assign out_of_range = |paddr[31:4];  // 16 and up
    assign pready       = (state == ST_RESP);  // one wait state
    assign pslverr      = pready && out_of_range;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (psel && penable) state <= ST_RESP;
                ST_RESP: state <= ST_IDLE;  // single pready pulse
                default: state <= ST_IDLE;
            endcase
        end
    end

    // read mux, zero on error or write
    always_comb begin
        prdata = '0;
        if (!out_of_range && !pwrite) begin
            prdata = {{(32 - CNT_W){1'b0}}, counts[sel*CNT_W +: CNT_W]};
        end
    end

    // clear lands on the pready edge
    always_comb begin
        clear = '0;
        if (pready && pwrite && !out_of_range) begin
            clear[sel] = 1'b1;
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel);

    // write data held through the wait state
    a_pwdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_IDLE && psel && penable && pwrite) |=> $stable(pwdata));

endmodule

//--- event_counter.sv
`timescale 1ns/100ps

module event_counter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [noc_pkg::EV_W-1:0]   router_event,
    input  logic                       clear,
    output logic [noc_pkg::CNT_W-1:0]  count
);
    import noc_pkg::*;

    logic [CNT_W:0] sum;  // carry bit flags overflow

    assign sum = {1'b0, count} + {{(CNT_W + 1 - EV_W){1'b0}}, router_event};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;  // wins over this cycle's events
        end else if (sum[CNT_W]) begin
            count <= '1;  // saturate
        end else begin
            count <= sum[CNT_W-1:0];
        end
    end

endmodule

//--- mesh_router.sv
`timescale 1ns/100ps

module mesh_router #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [noc_pkg::NP-1:0]               in_valid,
    input  logic [noc_pkg::NP*noc_pkg::FLIT_W-1:0] in_flit,
    output logic [noc_pkg::NP-1:0]               in_ready,
    output logic [noc_pkg::NP-1:0]               out_valid,
    output logic [noc_pkg::NP*noc_pkg::FLIT_W-1:0] out_flit,
    input  logic [noc_pkg::NP-1:0]               out_ready,
    output logic [noc_pkg::EV_W-1:0]             router_event
);
    import noc_pkg::*;

    logic [NP-1:0]     head_valid;  // per input buffer
    logic [FLIT_W-1:0] head_flit [NP];
    port_e             dest_port [NP];  // XY result per head
    logic [NP-1:0]     req_col [NP];  // requests per output
    logic [NP-1:0]     gnt [NP];  // grants per output
    logic [NP-1:0]     pop;  // buffer dequeues this cycle

    for (genvar i = 0; i < NP; i++) begin : g_in
        flit_fifo u_fifo (
            .clk      (clk),
            .rst_n    (rst_n),
            .wr_valid (in_valid[i]),
            .wr_flit  (in_flit[i*FLIT_W +: FLIT_W]),
            .wr_ready (in_ready[i]),
            .rd_valid (head_valid[i]),
            .rd_flit  (head_flit[i]),
            .rd_ready (pop[i])
        );

        // x first, then y, else eject
        always_comb begin
            if (int'(head_flit[i][DST_X_BIT]) > ROUTER_X) begin
                dest_port[i] = P_EAST;
            end else if (int'(head_flit[i][DST_X_BIT]) < ROUTER_X) begin
                dest_port[i] = P_WEST;
            end else if (int'(head_flit[i][DST_Y_BIT]) > ROUTER_Y) begin
                dest_port[i] = P_SOUTH;  // larger y is south
            end else if (int'(head_flit[i][DST_Y_BIT]) < ROUTER_Y) begin
                dest_port[i] = P_NORTH;
            end else begin
                dest_port[i] = P_LOCAL;
            end
        end
    end

    // request matrix, column per output
    always_comb begin
        for (int o = 0; o < NP; o++) begin
            for (int i = 0; i < NP; i++) begin
                req_col[o][i] = head_valid[i] && (int'(dest_port[i]) == o);
            end
        end
    end

    for (genvar o = 0; o < NP; o++) begin : g_out
        port_arbiter u_arb (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (req_col[o]),
            .done  (out_valid[o] && out_ready[o]),  // pointer moves on handshake
            .grant (gnt[o])
        );
        assign out_valid[o] = |gnt[o];
    end

    // crossbar, pop and event count
    always_comb begin
        out_flit     = '0;
        pop          = '0;
        router_event = '0;
        for (int o = 0; o < NP; o++) begin
            for (int i = 0; i < NP; i++) begin
                if (gnt[o][i]) begin
                    out_flit[o*FLIT_W +: FLIT_W] = head_flit[i];
                    pop[i] = pop[i] | out_ready[o];  // head leaves on accept
                end
            end
        end
        for (int i = 0; i < NP; i++) begin
            router_event = router_event + EV_W'(pop[i]);
        end
    end

endmodule

//--- port_arbiter.sv
`timescale 1ns/100ps

module port_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [noc_pkg::NP-1:0] req,
    input  logic                   done,
    output logic [noc_pkg::NP-1:0] grant
);
    import noc_pkg::*;

    logic [PORT_W-1:0] ptr;  // highest priority input
    logic [PORT_W-1:0] winner;
    logic [PORT_W:0]   scan;  // one spare bit, ptr + offset can pass NP

    // first requester at or after ptr, wrapping around
    always_comb begin
        grant  = '0;
        winner = ptr;
        scan   = '0;
        for (int i = 0; i < NP; i++) begin
            scan = {1'b0, ptr} + (PORT_W + 1)'(i);
            if (scan >= (PORT_W + 1)'(NP)) begin
                scan = scan - (PORT_W + 1)'(NP);  // wrap
            end
            if (req[scan[PORT_W-1:0]] && (grant == '0)) begin
                grant[scan[PORT_W-1:0]] = 1'b1;
                winner = scan[PORT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (done) begin  // move only on completed transfer
            if (winner == PORT_W'(NP - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= winner + PORT_W'(1);
            end
        end
    end

    // at most one grant, never to an idle input, done only under a grant
    a_grant_ok: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant) && ((grant & ~req) == '0) && (!done || (grant != '0)));

endmodule

//--- flit_fifo.sv
`timescale 1ns/100ps

module flit_fifo (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_valid,
    input  logic [noc_pkg::FLIT_W-1:0] wr_flit,
    output logic                       wr_ready,
    output logic                       rd_valid,
    output logic [noc_pkg::FLIT_W-1:0] rd_flit,
    input  logic                       rd_ready
);
    import noc_pkg::*;

    logic [FLIT_W-1:0] mem [2];  // two flit slots
    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        fill;  // 0, 1 or 2 entries
    logic              push;
    logic              pop;

    assign wr_ready = (fill != 2'd2);  // state only, low when full
    assign rd_valid = (fill != 2'd0);
    assign rd_flit  = mem[rd_ptr];  // head of buffer
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            fill   <= 2'd0;
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            case ({push, pop})
                2'b10:   fill <= fill + 2'd1;
                2'b01:   fill <= fill - 2'd1;
                default: fill <= fill;  // idle or push and pop together
            endcase
        end
    end

    // pointer distance must stay consistent with the fill count
    a_fill_max: assert property (@(posedge clk) disable iff (!rst_n)
        (fill <= 2'd2) && ((fill == 2'd1) == (wr_ptr != rd_ptr)));

endmodule

//--- noc_pkg.sv
package noc_pkg;

    localparam int NX = 2;  // mesh width
    localparam int NY = 2;  // mesh height
    localparam int NR = NX * NY;  // router count, id = y*NX + x
    localparam int NP = 5;  // ports per router
    localparam int PORT_W = 3;  // bits to index a port
    localparam int RID_W = 2;  // bits to index a router

    // flit layout, single-flit packets
    localparam int FLIT_W = 16;
    localparam int DST_X_BIT = 15;  // destination column
    localparam int DST_Y_BIT = 14;  // destination row

    localparam int EV_W = 3;  // 0..5 flits switched per cycle
    localparam int CNT_W = 16;  // statistics counter width

    // router ports, north faces lower y
    typedef enum logic [PORT_W-1:0] {
        P_LOCAL = 3'd0,
        P_EAST  = 3'd1,
        P_NORTH = 3'd2,
        P_WEST  = 3'd3,
        P_SOUTH = 3'd4
    } port_e;

    // statistics slave states
    typedef enum logic {
        ST_IDLE,  // waiting for access phase
        ST_RESP   // pready cycle
    } apb_state_e;

endpackage
